/* compile.f */
design/mips_pkg.sv
design/ctrl_if.sv
design/controller.sv
design/regfile.sv
design/datapath.sv
design/cpu_bus_interface.sv
design/mips.sv
tests/mips_checker.sv
tests/tb_mips.sv

/* design/controller.sv */
`timescale 1ns/1ps

module controller (
  input  logic [5:0] op,
  input  logic [5:0] funct,
  ctrl_if.dec        ctl,
  output logic       memop,
  output logic       memwrite
);
  import mips_pkg::*;

  always_comb begin
    // everything off unless the opcode is known
    ctl.regwrite   = 1'b0;
    ctl.regdst     = 1'b0;
    ctl.alusrc     = 1'b0;
    ctl.memtoreg   = 1'b0;
    ctl.branch     = 1'b0;
    ctl.jump       = 1'b0;
    ctl.jumpreg    = 1'b0;
    ctl.link       = 1'b0;
    ctl.mult       = 1'b0;
    ctl.mfhi       = 1'b0;
    ctl.mflo       = 1'b0;
    ctl.alucontrol = alu_add;
    memop          = 1'b0;
    memwrite       = 1'b0;

    case (op)
      op_rtype: begin
        ctl.regdst = 1'b1;
        case (funct)
          fn_add: begin ctl.regwrite = 1'b1; ctl.alucontrol = alu_add; end
          fn_sub: begin ctl.regwrite = 1'b1; ctl.alucontrol = alu_sub; end
          fn_and: begin ctl.regwrite = 1'b1; ctl.alucontrol = alu_and; end
          fn_or:  begin ctl.regwrite = 1'b1; ctl.alucontrol = alu_or;  end
          fn_slt: begin ctl.regwrite = 1'b1; ctl.alucontrol = alu_slt; end
          fn_jr:   ctl.jumpreg = 1'b1;
          fn_mult: ctl.mult    = 1'b1;   // hi/lo only, no register write
          fn_mfhi: begin ctl.regwrite = 1'b1; ctl.mfhi = 1'b1; end
          fn_mflo: begin ctl.regwrite = 1'b1; ctl.mflo = 1'b1; end
          default: ;                     // unknown funct is a no-op
        endcase
      end
      op_addi: begin
        ctl.regwrite = 1'b1;
        ctl.alusrc   = 1'b1;
      end
      op_lw: begin
        ctl.regwrite = 1'b1;
        ctl.alusrc   = 1'b1;             // address = rs + imm
        ctl.memtoreg = 1'b1;
        memop        = 1'b1;
      end
      op_sw: begin
        ctl.alusrc = 1'b1;
        memop      = 1'b1;
        memwrite   = 1'b1;
      end
      op_beq: begin
        ctl.branch     = 1'b1;
        ctl.alucontrol = alu_sub;        // zero result means equal
      end
      op_j:   ctl.jump = 1'b1;
      op_jal: begin
        ctl.jump     = 1'b1;
        ctl.link     = 1'b1;
        ctl.regwrite = 1'b1;
      end
      default: ;
    endcase
  end

  // a store that never reaches the bus sequencer would be silently lost
  always_comb begin
    if (memwrite) begin
      a_write_has_memop : assert (memop)
        else $error("controller: memwrite without memop, op=%h", op);
    end
  end

endmodule

/* design/cpu_bus_interface.sv */
`timescale 1ns/1ps

module cpu_bus_interface (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                memop,
  input  logic                bus_ack,
  input  mips_pkg::bus_ctrl_t bus_ctrl_in,
  input  mips_pkg::word_t     bus_data_in,
  input  mips_pkg::word_t     alu_out,
  input  mips_pkg::word_t     writedata,
  output logic                bus_req,
  output logic                pc_stall,
  output mips_pkg::word_t     readdata,
  output mips_pkg::word_t     bus_data_out
);
  import mips_pkg::*;

  bus_state_t state;
  bus_state_t state_next;
  logic       bus_wait;

  assign bus_wait = bus_ctrl_in[bus_wait_bit];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (memop)     state_next = st_addr;
      st_addr: if (bus_ack)   state_next = st_data;
      st_data: if (!bus_wait) state_next = st_done;
      st_done:                state_next = st_idle;  // instruction retires here
      default:                state_next = st_idle;
    endcase
  end

  assign bus_req  = (state == st_addr) || (state == st_data);
  assign pc_stall = memop && (state != st_done);   // freeze pc until done

  // address in the request phase, store data in the data phase
  assign bus_data_out = (state == st_data) ? writedata : alu_out;

  // last data-phase sample without wait is the load result
  always_ff @(posedge clk) begin
    if (state == st_data && !bus_wait) begin
      readdata <= bus_data_in;
    end
  end

  // the instruction must stay in decode for the whole access
  a_req_in_addr : assert property (@(posedge clk) disable iff (!arst_n)
    (state == st_addr) |-> bus_req && memop)
    else $error("cpu_bus_interface: addr phase without request or memop");

endmodule

/* design/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if;
  import mips_pkg::*;

  logic    regwrite;   // write result to register file
  logic    regdst;     // destination is rd, else rt
  logic    alusrc;     // alu b operand is the immediate
  logic    memtoreg;   // write back load data
  logic    branch;     // beq
  logic    jump;       // j / jal
  logic    jumpreg;    // jr
  logic    link;       // write pc+4 to ra
  logic    mult;       // load hi/lo with product
  logic    mfhi;
  logic    mflo;
  alu_op_t alucontrol;

  modport dec (output regwrite, regdst, alusrc, memtoreg, branch, jump, jumpreg,
               link, mult, mfhi, mflo, alucontrol);
  modport exe (input  regwrite, regdst, alusrc, memtoreg, branch, jump, jumpreg,
               link, mult, mfhi, mflo, alucontrol);

endinterface

/* design/datapath.sv */
`timescale 1ns/1ps

module datapath (
  input  logic                clk,
  input  logic                arst_n,
  ctrl_if.exe                 ctl,
  input  mips_pkg::word_t     instr,
  output mips_pkg::word_t     pc,
  output mips_pkg::word_t     alu_out,    // also the bus address
  output mips_pkg::word_t     writedata,
  input  mips_pkg::word_t     readdata,
  input  logic                pc_stall,
  input  mips_pkg::reg_addr_t debug_ra4,
  output mips_pkg::word_t     debug_rd4
);
  import mips_pkg::*;

  reg_addr_t          rs;
  reg_addr_t          rt;
  reg_addr_t          rd;
  reg_addr_t          wa;
  word_t              srca;
  word_t              srcb;
  word_t              rd2;
  word_t              signimm;
  word_t              result;
  word_t              pc_plus4;
  word_t              pc_branch;
  word_t              pc_jump;
  word_t              pc_next;
  word_t              hi;
  word_t              lo;
  logic signed [63:0] product;
  logic               zero;
  logic               take_branch;

  assign rs = instr[25:21];
  assign rt = instr[20:16];
  assign rd = instr[15:11];

  assign signimm = {{16{instr[15]}}, instr[15:0]};

  // jal always targets $ra
  assign wa = ctl.link   ? reg_ra :
              ctl.regdst ? rd     : rt;

  regfile rf (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (ctl.regwrite & ~pc_stall),  // no writes while a bus access is pending
    .ra1    (rs),
    .ra2    (rt),
    .ra4    (debug_ra4),
    .wa     (wa),
    .wd     (result),
    .rd1    (srca),
    .rd2    (rd2),
    .rd4    (debug_rd4)
  );

  assign writedata = rd2;
  assign srcb      = ctl.alusrc ? signimm : rd2;

  always_comb begin
    case (ctl.alucontrol)
      alu_add: alu_out = srca + srcb;
      alu_sub: alu_out = srca - srcb;
      alu_and: alu_out = srca & srcb;
      alu_or:  alu_out = srca | srcb;
      alu_slt: alu_out = {31'b0, $signed(srca) < $signed(srcb)};
      default: alu_out = '0;
    endcase
  end

  assign zero        = (alu_out == '0);
  assign take_branch = ctl.branch & zero;

  // write-back source
  always_comb begin
    if (ctl.link)          result = pc_plus4;
    else if (ctl.mfhi)     result = hi;
    else if (ctl.mflo)     result = lo;
    else if (ctl.memtoreg) result = readdata;
    else                   result = alu_out;
  end

  // signed product of the sign-extended 32-bit operands
  assign product = $signed({{32{srca[31]}}, srca}) * $signed({{32{rd2[31]}}, rd2});

  always_ff @(posedge clk) begin
    if (ctl.mult && !pc_stall) begin
      hi <= product[63:32];
      lo <= product[31:0];
    end
  end

  // next pc
  assign pc_plus4  = pc + 32'd4;
  assign pc_branch = pc_plus4 + {signimm[29:0], 2'b00};
  assign pc_jump   = {pc_plus4[31:28], instr[25:0], 2'b00};

  always_comb begin
    if (ctl.jumpreg)      pc_next = srca;       // jr rs
    else if (ctl.jump)    pc_next = pc_jump;
    else if (take_branch) pc_next = pc_branch;
    else                  pc_next = pc_plus4;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (!pc_stall) begin
      pc <= pc_next;
    end
  end

  // a jr to a misaligned register value would break fetch
  a_pc_aligned : assert property (@(posedge clk) disable iff (!arst_n)
    pc[1:0] == 2'b00)
    else $error("datapath: pc %h not word aligned", pc);

endmodule

/* design/mips.sv */
`timescale 1ns/1ps

module mips (
  input  logic                clk,
  input  logic                arst_n,
  input  mips_pkg::word_t     instr,
  output mips_pkg::word_t     pc,
  input  mips_pkg::bus_ctrl_t bus_ctrl_in,
  input  logic                bus_ack,
  input  mips_pkg::reg_addr_t debug_ra4,
  output mips_pkg::bus_ctrl_t bus_ctrl_out,
  output logic                bus_req,
  output mips_pkg::word_t     debug_rd4,
  input  mips_pkg::word_t     bus_data_in,
  output mips_pkg::word_t     bus_data_out
);
  import mips_pkg::*;

  logic  memop;
  logic  memwrite;
  logic  pc_stall;
  word_t alu_out;
  word_t writedata;
  word_t readdata;

  ctrl_if ctl ();

  // burst field 000 means single beat, wait output stays low
  always_comb begin
    bus_ctrl_out                = '0;
    bus_ctrl_out[bus_write_bit] = memwrite & bus_req;  // only during the access
  end

  controller c (
    .op       (instr[31:26]),
    .funct    (instr[5:0]),
    .ctl      (ctl.dec),
    .memop    (memop),
    .memwrite (memwrite)
  );

  datapath dp (
    .clk       (clk),
    .arst_n    (arst_n),
    .ctl       (ctl.exe),
    .instr     (instr),
    .pc        (pc),
    .alu_out   (alu_out),
    .writedata (writedata),
    .readdata  (readdata),
    .pc_stall  (pc_stall),
    .debug_ra4 (debug_ra4),
    .debug_rd4 (debug_rd4)
  );

  cpu_bus_interface bus_if (
    .clk          (clk),
    .arst_n       (arst_n),
    .memop        (memop),
    .bus_ack      (bus_ack),
    .bus_ctrl_in  (bus_ctrl_in),
    .bus_data_in  (bus_data_in),
    .alu_out      (alu_out),
    .writedata    (writedata),
    .bus_req      (bus_req),
    .pc_stall     (pc_stall),
    .readdata     (readdata),
    .bus_data_out (bus_data_out)
  );

endmodule

/* design/mips_pkg.sv */
package mips_pkg;

  // widths that carry a meaning
  typedef logic [31:0] word_t;      // data, address and instruction word
  typedef logic [4:0]  reg_addr_t;  // register number
  typedef logic [7:0]  bus_ctrl_t;  // shared-bus control byte

  // alu operation, classic single-cycle encoding
  typedef enum logic [2:0] {
    alu_and = 3'b000,
    alu_or  = 3'b001,
    alu_add = 3'b010,
    alu_sub = 3'b110,
    alu_slt = 3'b111
  } alu_op_t;

  // bus sequencer states
  typedef enum logic [1:0] {
    st_idle,
    st_addr,  // address on the bus, waiting for ack
    st_data,  // data phase, repeats while wait is high
    st_done   // access finished, instruction retires
  } bus_state_t;

  // primary opcodes, instr[31:26]
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_jal   = 6'h03;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_addi  = 6'h08;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;

  // r-type funct codes, instr[5:0]
  localparam logic [5:0] fn_jr   = 6'h08;
  localparam logic [5:0] fn_mfhi = 6'h10;
  localparam logic [5:0] fn_mflo = 6'h12;
  localparam logic [5:0] fn_mult = 6'h18;
  localparam logic [5:0] fn_add  = 6'h20;
  localparam logic [5:0] fn_sub  = 6'h22;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_slt  = 6'h2a;

  // bit positions in the bus control bytes
  localparam int unsigned bus_wait_bit  = 0;  // in bus_ctrl_in
  localparam int unsigned bus_write_bit = 1;  // in bus_ctrl_out

  // jal return address register
  localparam reg_addr_t reg_ra = 5'd31;

endpackage

/* design/regfile.sv */
`timescale 1ns/1ps

module regfile (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                we,
  input  mips_pkg::reg_addr_t ra1,
  input  mips_pkg::reg_addr_t ra2,
  input  mips_pkg::reg_addr_t ra4,   // debug port
  input  mips_pkg::reg_addr_t wa,
  input  mips_pkg::word_t     wd,
  output mips_pkg::word_t     rd1,
  output mips_pkg::word_t     rd2,
  output mips_pkg::word_t     rd4
);
  import mips_pkg::*;

  word_t regs [1:31];  // $zero has no storage

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  // combinational reads, register 0 reads as zero
  assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];
  assign rd4 = (ra4 == 5'd0) ? '0 : regs[ra4];

endmodule

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_mips -f compile.f -o sim_mips \
  && ./obj_dir/sim_mips | tee /dev/stderr | grep -q "Simulation PASSED" \
  && echo "run ok" \
  || { echo "run failed"; exit 1; }

/* tests/mips_checker.sv */
`timescale 1ns/1ps

module mips_checker (
  input logic                clk,
  input logic                arst_n,
  input logic                bus_req,
  input logic                bus_ack,
  input mips_pkg::bus_ctrl_t bus_ctrl_in,
  input mips_pkg::bus_ctrl_t bus_ctrl_out,
  input mips_pkg::word_t     bus_data_out,
  input mips_pkg::word_t     pc
);
  import mips_pkg::*;

  word_t     exp_addr [$];    // expected stores in program order
  word_t     exp_data [$];
  word_t     cur_data;
  word_t     held_pc;
  bus_ctrl_t ctrl_exp;
  logic      pending;         // store address seen and data phase still open
  logic      req_d;
  int        tests  = 0;
  int        errors = 0;

  task automatic add_store(input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  function automatic int stores_left();
    return exp_addr.size();
  endfunction

  task automatic compare_value(input string name, input word_t actual, input word_t expected);
    tests++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end else begin
      $display("ok   %s = %h", name, actual);
    end
  endtask

  always @(posedge clk) begin
    if (!arst_n) begin
      pending <= 1'b0;
      req_d   <= 1'b0;
    end else begin
      req_d <= bus_req;
      if (bus_req && !req_d) held_pc <= pc;  // start of an access
      if (bus_req && req_d && pc !== held_pc) begin
        errors++;
        $display("Fail at %0d ns: pc is %h, expected %h", $time, pc, held_pc);
      end
      // burst and wait fields stay zero and the write flag only shows inside an access
      ctrl_exp                = '0;
      ctrl_exp[bus_write_bit] = bus_req & bus_ctrl_out[bus_write_bit];
      if (bus_ctrl_out !== ctrl_exp) begin
        errors++;
        $display("Fail at %0d ns: bus_ctrl_out is %h, expected %h", $time,
                 bus_ctrl_out, ctrl_exp);
      end
      // address phase of a store ends on ack
      if (bus_req && bus_ack && bus_ctrl_out[bus_write_bit]) begin
        if (exp_addr.size() == 0) begin
          errors++;
          $display("Error at %0d ns: the core made a store that the program should not make",
                   $time);
        end else begin
          if (bus_data_out !== exp_addr[0]) begin
            errors++;
            $display("Fail at %0d ns: bus_data_out is %h, expected %h", $time,
                     bus_data_out, exp_addr[0]);
          end
          void'(exp_addr.pop_front());
          cur_data <= exp_data.pop_front();
          pending  <= 1'b1;
        end
      end
      // data phase closes on the first cycle without wait
      if (pending && bus_req && !bus_ack && !bus_ctrl_in[bus_wait_bit]) begin
        pending <= 1'b0;
        compare_value("store data", bus_data_out, cur_data);
      end
    end
  end

endmodule

/* tests/program_cases.mem */
# P word_index instruction | S store_address store_data
# R register value | D byte_address initial_data
P 00 20010007
P 01 2002FFFD
P 02 00221820
P 03 00222022
P 04 00222824
P 05 00223025
P 06 0041382A
P 07 00220018
P 08 00004010
P 09 00004812
P 0A 8C0A0040
P 0B 8C0B0044
P 0C 014B6020
P 0D AC0C0080
P 0E 10210001
P 0F 200E0BAD
P 10 10220001
P 11 200F0055
P 12 0C000014
P 13 08000016
P 14 20110077
P 15 03E00008
P 16 AC0F0084
P 17 08000017
D 40 12345678
D 44 FFFFFFF0
S 80 12345668
S 84 00000055
R 03 00000004
R 04 0000000A
R 05 00000005
R 06 FFFFFFFF
R 07 00000001
R 08 FFFFFFFF
R 09 FFFFFFEB
R 0C 12345668
R 0E 00000000
R 0F 00000055
R 11 00000077
R 1F 0000004C

/* tests/tb_mips.sv */
`timescale 1ns/1ps

module tb_mips;
  import mips_pkg::*;

  logic      clk;
  logic      arst_n;
  word_t     instr;
  word_t     pc;
  bus_ctrl_t bus_ctrl_in;
  bus_ctrl_t bus_ctrl_out;
  logic      bus_ack;
  logic      bus_req;
  reg_addr_t debug_ra4;
  word_t     debug_rd4;
  word_t     bus_data_in;
  word_t     bus_data_out;

  word_t     rom [0:255];
  word_t     ram [0:255];
  word_t     reg_exp [0:31];
  logic      reg_chk [0:31];
  word_t     end_pc;
  logic      cases_ok;
  logic      timed_out;
  integer    seed = 44;
  int        delay;
  int        cnt;
  int        waits;
  logic      in_data;
  logic      is_write;
  logic [7:0] idx;

  mips UUT (.*);
  mips_checker chk (.*);

  assign instr = rom[pc[9:2]];  // combinational instruction ROM

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic read_cases();
    integer              fd;
    integer              n;
    logic [8*256-1:0]    line;
    logic [7:0]          tag;
    word_t               a;
    word_t               b;
    fd = $fopen("tests/program_cases.mem", "r");
    cases_ok = (fd != 0);
    if (fd == 0) begin
      $display("cannot open tests/program_cases.mem");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%s %h %h", tag, a, b);
      if (n == 3 && tag != "#") begin
        case (tag)
          "P": begin
            rom[a[7:0]] = b;
            if ((a << 2) > end_pc) end_pc = a << 2;  // last word is the end loop
          end
          "S": chk.add_store(a, b);
          "R": begin
            reg_exp[a[4:0]] = b;
            reg_chk[a[4:0]] = 1'b1;
          end
          "D": ram[a[9:2]] = b;
          default: $display("unknown record in tests/program_cases.mem");
        endcase
      end
    end
    $fclose(fd);
  endtask

  // bus slave with random ack delay and wait cycles
  always @(negedge clk) begin
    if (!arst_n || !bus_req) begin
      in_data     = 1'b0;
      cnt         = 0;
      delay       = $random(seed) & 3;
      bus_ack     = 1'b0;
      bus_ctrl_in = '0;
    end else if (!in_data) begin
      idx      = bus_data_out[9:2];
      is_write = bus_ctrl_out[bus_write_bit];
      if (cnt >= delay) begin
        bus_ack = 1'b1;
        in_data = 1'b1;
        waits   = 0;
      end else begin
        cnt++;
      end
    end else begin
      bus_ack = 1'b0;
      if (waits < 3 && ($random(seed) & 1) != 0) begin
        bus_ctrl_in = 8'h01;
        waits++;
      end else begin
        bus_ctrl_in = '0;
        if (is_write) ram[idx] = bus_data_out;
      end
      bus_data_in = ram[idx];
    end
  end

  initial begin
    int cycles;
    arst_n      = 1'b1;
    bus_ack     = 1'b0;
    bus_ctrl_in = '0;
    bus_data_in = '0;
    debug_ra4   = '0;
    end_pc      = '0;
    timed_out   = 1'b0;
    for (int i = 0; i < 256; i++) begin
      rom[i] = '0;                           // sll $0 decodes as a no-op
      ram[i] = 32'hdead0000 | (i << 2);      // unwritten words show their address
    end
    for (int r = 0; r < 32; r++) reg_chk[r] = 1'b0;
    read_cases();
    #1 arst_n = 1'b0;
    #1;
    chk.compare_value("pc after reset", pc, '0);
    chk.compare_value("bus_req after reset", {31'b0, bus_req}, '0);
    chk.compare_value("bus_ctrl_out after reset", {24'b0, bus_ctrl_out}, '0);
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    cycles = 0;
    while (cases_ok && pc !== end_pc && cycles < 4000) begin
      @(negedge clk);
      cycles++;
    end
    if (!cases_ok || pc !== end_pc) begin
      timed_out = 1'b1;
      $display("timeout: program did not reach end marker at pc %h", end_pc);
    end else begin
      for (int r = 0; r < 32; r++) begin
        if (reg_chk[r]) begin
          @(negedge clk) debug_ra4 = r[4:0];
          @(posedge clk);
          chk.compare_value($sformatf("debug_rd4 r%0d", r), debug_rd4, reg_exp[r]);
        end
      end
      if (chk.stores_left() != 0) begin
        chk.errors++;
        $display("%0d expected stores never appeared on the bus", chk.stores_left());
      end
    end
    $display("checks %0d, errors %0d", chk.tests, chk.errors);
    if (!timed_out && chk.errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
